// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  // major opcode, instruction bits [30:25]
  typedef enum logic [5:0] {
    OP_ALU  = 6'b100000,
    OP_MOVI = 6'b100010,
    OP_ADDI = 6'b101000,
    OP_XORI = 6'b101011,
    OP_ORI  = 6'b101100,
    OP_SWI  = 6'b011010
  } opcode_e;

  // alu group sub-opcode, bits [4:0]
  // a NOP is SRLI r0, r0, 0
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } sub_op_e;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_WRITE,
    ST_STORE
  } ctrl_state_e;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_sel_e;

  typedef enum logic {
    WB_ALU  = 1'b0,
    WB_SRC2 = 1'b1
  } wb_sel_e;

  typedef enum logic {
    OPND_REG = 1'b0,
    OPND_IMM = 1'b1
  } opnd_sel_e;

  // instruction field positions
  localparam int OPCODE_MSB = 30;
  localparam int OPCODE_LSB = 25;
  localparam int RT_LSB     = 20;
  localparam int RA_LSB     = 15;
  localparam int RB_LSB     = 10;
  localparam int IMM5_LSB   = 10;
  localparam int IMM15_MSB  = 14;
  localparam int IMM20_MSB  = 19;
  localparam int SUB_OP_MSB = 4;

  localparam int unsigned RESET_PC = 0;

endpackage

// ==== common/ctrl_if.sv ====
`timescale 1ns/1ps

// controller to datapath control and result signals
interface ctrl_if #(
  parameter int data_width = 32
);

  logic [data_width-1:0] instruction;
  logic                  reg_read_en;
  logic                  alu_en;
  logic                  reg_write_en;
  cpu_pkg::imm_sel_e     imm_sel;
  cpu_pkg::opnd_sel_e    opnd_sel;
  cpu_pkg::wb_sel_e      wb_sel;

  // store address and store data back to the controller
  logic [data_width-1:0] alu_result;
  logic [data_width-1:0] store_data;

  modport controller (
    output instruction, reg_read_en, alu_en, reg_write_en,
    output imm_sel, opnd_sel, wb_sel,
    input  alu_result, store_data
  );

  modport datapath (
    input  instruction, reg_read_en, alu_en, reg_write_en,
    input  imm_sel, opnd_sel, wb_sel,
    output alu_result, store_data
  );

endinterface

// ==== datapath/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  read_en,
  input  logic                  write_en,
  input  logic [addr_width-1:0] read_addr1,
  input  logic [addr_width-1:0] read_addr2,
  input  logic [addr_width-1:0] write_addr,
  input  logic [data_width-1:0] write_data,
  output logic [data_width-1:0] read_data1,
  output logic [data_width-1:0] read_data2
);

  localparam int depth = 2 ** addr_width;

  // r0 is an ordinary register here
  logic [data_width-1:0] regs [depth];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
      read_data1 <= '0;
      read_data2 <= '0;
    end else begin
      if (write_en) begin
        regs[write_addr] <= write_data;
      end
      // registered read ports
      if (read_en) begin
        read_data1 <= regs[read_addr1];
        read_data2 <= regs[read_addr2];
      end
    end
  end

endmodule

// ==== datapath/alu.sv ====
`timescale 1ns/1ps

module alu #(
  parameter int data_width = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alu_en,
  input  cpu_pkg::opcode_e      operation,
  input  cpu_pkg::sub_op_e      sub_op,
  input  logic [data_width-1:0] src1,
  input  logic [data_width-1:0] src2,
  output logic [data_width-1:0] result
);

  logic [4:0]              shamt;
  logic [2*data_width-1:0] rot_wide;
  logic [data_width-1:0]   next_result;

  assign shamt    = src2[4:0];
  // rotate right through a doubled word
  assign rot_wide = {src1, src1} >> shamt;

  always_comb begin
    next_result = result;
    case (operation)
      cpu_pkg::OP_ALU: begin
        case (sub_op)
          cpu_pkg::ADD:   next_result = src1 + src2;
          cpu_pkg::SUB:   next_result = src1 - src2;
          cpu_pkg::AND:   next_result = src1 & src2;
          cpu_pkg::OR:    next_result = src1 | src2;
          cpu_pkg::XOR:   next_result = src1 ^ src2;
          cpu_pkg::SLLI:  next_result = src1 << shamt;
          cpu_pkg::SRLI:  next_result = src1 >> shamt;
          cpu_pkg::ROTRI: next_result = rot_wide[data_width-1:0];
          default:        next_result = result;
        endcase
      end
      // swi computes its address here
      cpu_pkg::OP_ADDI,
      cpu_pkg::OP_SWI:  next_result = src1 + src2;
      cpu_pkg::OP_ORI:  next_result = src1 | src2;
      cpu_pkg::OP_XORI: next_result = src1 ^ src2;
      cpu_pkg::OP_MOVI: next_result = src2;
      default:          next_result = result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (alu_en) begin
      result <= next_result;
    end
  end

endmodule

// ==== datapath/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic    clock,
  input  logic    reset,
  ctrl_if.datapath ctrl
);

  cpu_pkg::opcode_e      opcode;
  cpu_pkg::sub_op_e      sub_op;
  logic [addr_width-1:0] rt_addr;
  logic [addr_width-1:0] ra_addr;
  logic [addr_width-1:0] rb_addr;
  logic [addr_width-1:0] read_addr2;
  logic [4:0]            imm5;
  logic [14:0]           imm15;
  logic [19:0]           imm20;
  logic [data_width-1:0] imm_ext;
  logic [data_width-1:0] src1;
  logic [data_width-1:0] reg_src2;
  logic [data_width-1:0] src2;
  logic [data_width-1:0] alu_result;
  logic [data_width-1:0] write_data;

  assign opcode = cpu_pkg::opcode_e'(ctrl.instruction[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);
  assign sub_op = cpu_pkg::sub_op_e'(ctrl.instruction[cpu_pkg::SUB_OP_MSB:0]);

  assign rt_addr = ctrl.instruction[cpu_pkg::RT_LSB +: addr_width];
  assign ra_addr = ctrl.instruction[cpu_pkg::RA_LSB +: addr_width];
  assign rb_addr = ctrl.instruction[cpu_pkg::RB_LSB +: addr_width];

  assign imm5  = ctrl.instruction[cpu_pkg::IMM5_LSB +: 5];
  assign imm15 = ctrl.instruction[cpu_pkg::IMM15_MSB:0];
  assign imm20 = ctrl.instruction[cpu_pkg::IMM20_MSB:0];

  // a store reads rt on the second port in place of rb
  assign read_addr2 = (opcode == cpu_pkg::OP_SWI) ? rt_addr : rb_addr;

  always_comb begin
    case (ctrl.imm_sel)
      cpu_pkg::IMM5_ZE:  imm_ext = {{(data_width-5){1'b0}}, imm5};
      cpu_pkg::IMM15_SE: imm_ext = {{(data_width-15){imm15[14]}}, imm15};
      cpu_pkg::IMM15_ZE: imm_ext = {{(data_width-15){1'b0}}, imm15};
      cpu_pkg::IMM20_SE: imm_ext = {{(data_width-20){imm20[19]}}, imm20};
      default:           imm_ext = '0;
    endcase
  end

  assign src2 = (ctrl.opnd_sel == cpu_pkg::OPND_IMM) ? imm_ext : reg_src2;

  // movi writes its immediate straight back
  assign write_data = (ctrl.wb_sel == cpu_pkg::WB_SRC2) ? imm_ext : alu_result;

  register_file #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_register_file (
    .clock      (clock),
    .reset      (reset),
    .read_en    (ctrl.reg_read_en),
    .write_en   (ctrl.reg_write_en),
    .read_addr1 (ra_addr),
    .read_addr2 (read_addr2),
    .write_addr (rt_addr),
    .write_data (write_data),
    .read_data1 (src1),
    .read_data2 (reg_src2)
  );

  alu #(
    .data_width (data_width)
  ) u_alu (
    .clock     (clock),
    .reset     (reset),
    .alu_en    (ctrl.alu_en),
    .operation (opcode),
    .sub_op    (sub_op),
    .src1      (src1),
    .src2      (src2),
    .result    (alu_result)
  );

  assign ctrl.alu_result = alu_result;
  assign ctrl.store_data = reg_src2;

endmodule

// ==== hdl/ir_controller.sv ====
`timescale 1ns/1ps

module ir_controller #(
  parameter int data_width = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  output logic [data_width-1:0] wb_adr,
  output logic [data_width-1:0] wb_dat_w,
  output logic                  wb_we,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  input  logic [data_width-1:0] wb_dat_r,
  input  logic                  wb_ack,
  ctrl_if.controller            ctrl
);

  cpu_pkg::ctrl_state_e  state;
  logic [data_width-1:0] pc;
  logic [data_width-1:0] ir;
  cpu_pkg::opcode_e      opcode;
  cpu_pkg::sub_op_e      sub_op;
  logic                  is_shift;
  logic                  bus_start;
  logic                  bus_done;

  assign opcode = cpu_pkg::opcode_e'(ir[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);
  assign sub_op = cpu_pkg::sub_op_e'(ir[cpu_pkg::SUB_OP_MSB:0]);

  assign is_shift = sub_op inside {cpu_pkg::SLLI, cpu_pkg::SRLI, cpu_pkg::ROTRI};

  // a bus cycle opens on the first cycle of fetch or store
  assign bus_start = !wb_cyc && (state == cpu_pkg::ST_FETCH || state == cpu_pkg::ST_STORE);
  assign bus_done  = wb_cyc && wb_ack;

  // state sequencing and bus control
  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= cpu_pkg::ST_FETCH;
      pc     <= data_width'(cpu_pkg::RESET_PC);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      case (state)
        cpu_pkg::ST_FETCH: begin
          if (bus_start) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= 1'b0;
          end else if (bus_done) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            pc     <= pc + data_width'(4);
            state  <= cpu_pkg::ST_DECODE;
          end
        end
        cpu_pkg::ST_DECODE: begin
          state <= cpu_pkg::ST_EXECUTE;
        end
        cpu_pkg::ST_EXECUTE: begin
          case (opcode)
            cpu_pkg::OP_SWI:  state <= cpu_pkg::ST_STORE;
            cpu_pkg::OP_ALU,
            cpu_pkg::OP_ADDI,
            cpu_pkg::OP_ORI,
            cpu_pkg::OP_XORI,
            cpu_pkg::OP_MOVI: state <= cpu_pkg::ST_WRITE;
            // unknown opcode, skip it
            default:          state <= cpu_pkg::ST_FETCH;
          endcase
        end
        cpu_pkg::ST_WRITE: begin
          state <= cpu_pkg::ST_FETCH;
        end
        cpu_pkg::ST_STORE: begin
          if (bus_start) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= 1'b1;
          end else if (bus_done) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            state  <= cpu_pkg::ST_FETCH;
          end
        end
        default: begin
          state <= cpu_pkg::ST_FETCH;
        end
      endcase
    end
  end

  // bus address, write data and instruction register
  always_ff @(posedge clock) begin
    if (bus_start) begin
      if (state == cpu_pkg::ST_STORE) begin
        wb_adr   <= ctrl.alu_result;
        wb_dat_w <= ctrl.store_data;
      end else begin
        wb_adr <= pc;
      end
    end
    if (state == cpu_pkg::ST_FETCH && bus_done) begin
      ir <= wb_dat_r;
    end
  end

  assign ctrl.instruction  = ir;
  assign ctrl.reg_read_en  = (state == cpu_pkg::ST_DECODE);
  assign ctrl.alu_en       = (state == cpu_pkg::ST_EXECUTE);
  assign ctrl.reg_write_en = (state == cpu_pkg::ST_WRITE);

  // operand and writeback selection
  always_comb begin
    ctrl.imm_sel  = cpu_pkg::IMM5_ZE;
    ctrl.opnd_sel = cpu_pkg::OPND_REG;
    ctrl.wb_sel   = cpu_pkg::WB_ALU;
    case (opcode)
      cpu_pkg::OP_ALU: begin
        ctrl.opnd_sel = is_shift ? cpu_pkg::OPND_IMM : cpu_pkg::OPND_REG;
      end
      cpu_pkg::OP_ADDI,
      cpu_pkg::OP_SWI: begin
        ctrl.imm_sel  = cpu_pkg::IMM15_SE;
        ctrl.opnd_sel = cpu_pkg::OPND_IMM;
      end
      cpu_pkg::OP_ORI,
      cpu_pkg::OP_XORI: begin
        ctrl.imm_sel  = cpu_pkg::IMM15_ZE;
        ctrl.opnd_sel = cpu_pkg::OPND_IMM;
      end
      cpu_pkg::OP_MOVI: begin
        ctrl.imm_sel  = cpu_pkg::IMM20_SE;
        ctrl.opnd_sel = cpu_pkg::OPND_IMM;
        ctrl.wb_sel   = cpu_pkg::WB_SRC2;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic                  clock,
  input  logic                  reset,
  // wishbone classic master
  output logic [data_width-1:0] wb_adr,
  output logic [data_width-1:0] wb_dat_w,
  input  logic [data_width-1:0] wb_dat_r,
  output logic                  wb_we,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  input  logic                  wb_ack
);

  ctrl_if #(
    .data_width (data_width)
  ) u_ctrl_if ();

  ir_controller #(
    .data_width (data_width)
  ) u_ir_controller (
    .clock    (clock),
    .reset    (reset),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .ctrl     (u_ctrl_if.controller)
  );

  datapath #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_datapath (
    .clock (clock),
    .reset (reset),
    .ctrl  (u_ctrl_if.datapath)
  );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int period       = 10,
  parameter int reset_cycles = 5
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // reset drops on a rising edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// ==== bench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

  localparam int data_width = 32;
  localparam int addr_width = 5;
  // SRLI r0, r0, 0
  localparam logic [31:0] nop_word = 32'h4000_0009;

  logic        clock;
  logic        reset;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r = 32'h0;
  logic        wb_we;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_ack = 1'b0;

  integer      seed = 32'h262;
  logic [1:0]  wait_left = 2'd0;
  logic [31:0] fetch_addr = 32'h0;
  int          transfers = 0;
  int          cycle_count = 0;
  int          timeout_cycles = 0;
  int          stores_checked = 0;

  logic [31:0] prog_rom [$];
  logic [63:0] exp_store [$];
  // address and data of each acknowledged write
  logic [63:0] store_q [$];

  clock_gen #(
    .period       (10),
    .reset_cycles (5)
  ) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  cpu_top #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_cpu_top (
    .clock    (clock),
    .reset    (reset),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack)
  );

  function automatic logic [31:0] alu_word(input cpu_pkg::sub_op_e sub, input logic [4:0] rt,
                                           input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, cpu_pkg::OP_ALU, rt, ra, rb, 5'b0, sub};
  endfunction

  function automatic logic [31:0] imm15_word(input cpu_pkg::opcode_e op, input logic [4:0] rt,
                                             input logic [4:0] ra, input logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic logic [31:0] movi_word(input logic [4:0] rt, input logic [19:0] imm);
    return {1'b0, cpu_pkg::OP_MOVI, rt, imm};
  endfunction

  function automatic logic [1:0] next_wait();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[1:0];
  endfunction

  // past the end of the program the memory returns NOPs
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    int idx;
    idx = int'(addr[31:2]);
    if (idx < prog_rom.size()) begin
      return prog_rom[idx];
    end
    return nop_word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // memory slave with 0 to 3 wait states
  always @(posedge clock) begin
    if (reset) begin
      wb_ack    <= 1'b0;
      wait_left <= next_wait();
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        if (transfers == 0) begin
          check_value("wb_we", {31'b0, wb_we}, 32'h0);
        end
        if (wb_we) begin
          store_q.push_back({wb_adr, wb_dat_w});
        end else begin
          check_value("wb_adr", wb_adr, fetch_addr);
          fetch_addr <= fetch_addr + 32'd4;
          wb_dat_r   <= fetch_word(wb_adr);
        end
        wb_ack    <= 1'b1;
        wait_left <= next_wait();
        transfers <= transfers + 1;
      end
    end
  end

  always @(posedge clock) begin
    if (!reset) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
        $display("processor stopped storing: %0d of %0d stores seen after %0d cycles",
                 stores_checked, exp_store.size(), cycle_count);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    logic [63:0] entry;
    prog_rom.push_back(movi_word(5'd1, 20'h00100));
    prog_rom.push_back(movi_word(5'd2, 20'hfff85));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd2, 5'd1, 15'h0000));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_ADDI, 5'd3, 5'd2, 15'h7ff0));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd3, 5'd1, 15'h0004));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_ORI, 5'd4, 5'd1, 15'h5a5a));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd4, 5'd1, 15'h0008));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_XORI, 5'd5, 5'd2, 15'h7fff));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd5, 5'd1, 15'h000c));
    prog_rom.push_back(movi_word(5'd6, 20'h12345));
    prog_rom.push_back(movi_word(5'd7, 20'h8f0f0));
    prog_rom.push_back(alu_word(cpu_pkg::ADD, 5'd8, 5'd6, 5'd7));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd8, 5'd1, 15'h0010));
    prog_rom.push_back(alu_word(cpu_pkg::SUB, 5'd9, 5'd6, 5'd7));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd9, 5'd1, 15'h0014));
    prog_rom.push_back(alu_word(cpu_pkg::AND, 5'd10, 5'd6, 5'd7));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd10, 5'd1, 15'h0018));
    prog_rom.push_back(alu_word(cpu_pkg::OR, 5'd11, 5'd6, 5'd7));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd11, 5'd1, 15'h001c));
    prog_rom.push_back(alu_word(cpu_pkg::XOR, 5'd12, 5'd6, 5'd7));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd12, 5'd1, 15'h0020));
    // shift amount sits in the rb field
    prog_rom.push_back(alu_word(cpu_pkg::SLLI, 5'd13, 5'd7, 5'd4));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd13, 5'd1, 15'h0024));
    prog_rom.push_back(alu_word(cpu_pkg::SRLI, 5'd14, 5'd7, 5'd12));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd14, 5'd1, 15'h0028));
    prog_rom.push_back(alu_word(cpu_pkg::ROTRI, 5'd15, 5'd6, 5'd8));
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd15, 5'd1, 15'h002c));
    // offset of -8
    prog_rom.push_back(imm15_word(cpu_pkg::OP_SWI, 5'd6, 5'd1, 15'h7ff8));

    exp_store.push_back({32'h0000_0100, 32'hffff_ff85});
    exp_store.push_back({32'h0000_0104, 32'hffff_ff75});
    exp_store.push_back({32'h0000_0108, 32'h0000_5b5a});
    exp_store.push_back({32'h0000_010c, 32'hffff_807a});
    exp_store.push_back({32'h0000_0110, 32'hfffa_1435});
    exp_store.push_back({32'h0000_0114, 32'h0008_3255});
    exp_store.push_back({32'h0000_0118, 32'h0000_2040});
    exp_store.push_back({32'h0000_011c, 32'hfff9_f3f5});
    exp_store.push_back({32'h0000_0120, 32'hfff9_d3b5});
    exp_store.push_back({32'h0000_0124, 32'hff8f_0f00});
    exp_store.push_back({32'h0000_0128, 32'h000f_ff8f});
    exp_store.push_back({32'h0000_012c, 32'h4500_0123});
    exp_store.push_back({32'h0000_00f8, 32'h0001_2345});

    // worst case per instruction is a slow fetch plus a slow store
    timeout_cycles = prog_rom.size() * 14;

    for (int i = 0; i < exp_store.size(); i++) begin
      while (store_q.size() == 0) begin
        @(negedge clock);
      end
      entry = store_q.pop_front();
      check_value("wb_adr", entry[63:32], exp_store[i][63:32]);
      check_value("wb_dat_w", entry[31:0], exp_store[i][31:0]);
      stores_checked = stores_checked + 1;
    end

    // let the first NOP past the program run to completion
    while (fetch_addr < (prog_rom.size() + 2) * 4) begin
      @(negedge clock);
    end

    if (store_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("processor wrote more words to the bus than the program stores");
      $display("*** FAILED ***");
      $fatal(1, "extra store");
    end
  end

endmodule

// ==== sim.f ====
common/cpu_pkg.sv
common/ctrl_if.sv
datapath/register_file.sv
datapath/alu.sv
datapath/datapath.sv
hdl/ir_controller.sv
hdl/cpu_top.sv
bench/clock_gen.sv
bench/tb_cpu.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_cpu
FILELIST := sim.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)
